/* verilog/uart_cfg_pkg.sv */
// uart receive configuration: widths of counters and words, oversampling and frame defaults
package uart_cfg_pkg;

   // one received data word, DBIT of its bits are used
   typedef logic [7:0] data_t;

   // tick counter inside one bit time
   typedef logic [3:0] os_cnt_t;

   // index of the data bit being received
   typedef logic [2:0] bit_cnt_t;

   // clk cycles per oversampling tick
   typedef logic [15:0] baud_div_t;

   // consecutive low ticks on the line
   typedef logic [7:0] break_cnt_t;

   // ticks per bit time
   localparam int OS_RATE = 16;

   // data bits per frame, no parity, one stop bit
   localparam int DEFAULT_DBIT = 8;

   // 50 MHz clk, 9600 baud, 16x oversampling
   localparam baud_div_t DEFAULT_BAUD_DIV = 16'd326;

endpackage

/* verilog/uart_frame_pkg.sv */
// uart receive payloads: frame result from the receiver and the report sent out
package uart_frame_pkg;

   import uart_cfg_pkg::*;

   // result of one frame, valid with frame_valid
   typedef struct packed {
      data_t data;
      logic  framing_error;
   } rx_frame_t;

   // report to the consumer, valid with report_valid
   // a break report has data zero and line_break set
   typedef struct packed {
      data_t data;
      logic  framing_error;
      logic  line_break;
      // a break event had to wait behind another event
      logic  overrun;
   } rx_report_t;

endpackage

/* verilog/baud_tick_gen.sv */
// baud tick generator, divides clk into the 16x oversampling strobe
`timescale 1ns/1ps

module baud_tick_gen
   import uart_cfg_pkg::*;
   #(
      parameter baud_div_t BAUD_DIV = DEFAULT_BAUD_DIV
   )
   (
      input  logic clk,
      input  logic reset,
      output logic s_tick
   );

   localparam baud_div_t TICK_LAST = BAUD_DIV - baud_div_t'(1);

   baud_div_t count;

   // free running, wraps on the last count
   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
         count <= '0;
      else if (count == TICK_LAST)
         count <= '0;
      else
         count <= count + 1'b1;
   end

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
         s_tick <= 1'b0;
      else
         s_tick <= (count == TICK_LAST);
   end

   // strobe is a single cycle unless every cycle is a tick
   a_tick_single: assert property (
      @(posedge clk) disable iff (reset)
      (BAUD_DIV > 1) && s_tick |=> !s_tick
   );

endmodule

/* verilog/uart_rx.sv */
// uart frame receiver, samples start, data and stop bits mid-bit at 16x oversampling
`timescale 1ns/1ps

module uart_rx
   import uart_cfg_pkg::*;
   import uart_frame_pkg::*;
   #(
      parameter int DBIT = DEFAULT_DBIT
   )
   (
      input  logic      clk,
      input  logic      reset,
      input  logic      rx,
      input  logic      s_tick,
      output rx_frame_t frame,
      output logic      frame_valid
   );

   localparam os_cnt_t  MID_TICK  = os_cnt_t'(OS_RATE / 2 - 1);
   localparam os_cnt_t  LAST_TICK = os_cnt_t'(OS_RATE - 1);
   localparam bit_cnt_t LAST_BIT  = bit_cnt_t'(DBIT - 1);
   localparam int       ALIGN     = $bits(data_t) - DBIT;

   typedef enum logic [2:0] {
      idle,
      start,
      data,
      stop,
      rearm
   } state_t;

   state_t   state_reg;
   state_t   state_next;
   os_cnt_t  s_reg;
   os_cnt_t  s_next;
   bit_cnt_t n_reg;
   bit_cnt_t n_next;
   data_t    b_reg;
   logic     shift_en;

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         state_reg <= idle;
         s_reg     <= '0;
         n_reg     <= '0;
      end
      else
      begin
         state_reg <= state_next;
         s_reg     <= s_next;
         n_reg     <= n_next;
      end
   end

   // lsb arrives first and shifts in from the top
   always_ff @(posedge clk)
   begin
      if (shift_en)
         b_reg <= {rx, b_reg[$bits(data_t)-1:1]};
   end

   always_comb
   begin
      state_next  = state_reg;
      s_next      = s_reg;
      n_next      = n_reg;
      shift_en    = 1'b0;
      frame_valid = 1'b0;
      case (state_reg)
         idle:
            if (!rx)
            begin
               state_next = start;
               s_next     = '0;
            end
         // wait to the middle of the start bit without checking its level
         start:
            if (s_tick)
            begin
               if (s_reg == MID_TICK)
               begin
                  state_next = data;
                  s_next     = '0;
                  n_next     = '0;
               end
               else
                  s_next = s_reg + 1'b1;
            end
         data:
            if (s_tick)
            begin
               if (s_reg == LAST_TICK)
               begin
                  s_next   = '0;
                  shift_en = 1'b1;
                  if (n_reg == LAST_BIT)
                     state_next = stop;
                  else
                     n_next = n_reg + 1'b1;
               end
               else
                  s_next = s_reg + 1'b1;
            end
         stop:
            if (s_tick)
            begin
               if (s_reg == LAST_TICK)
               begin
                  frame_valid = 1'b1;
                  state_next  = rx ? idle : rearm;
               end
               else
                  s_next = s_reg + 1'b1;
            end
         // after a low stop bit hold off until the line is seen high on a tick
         rearm:
            if (s_tick && rx)
               state_next = idle;
         default:
            state_next = idle;
      endcase
   end

   // short words end up in the upper bits and are moved down
   assign frame.data          = b_reg >> ALIGN;
   assign frame.framing_error = !rx;

   // the stop sample comes on a tick after the last data bit
   a_frame_on_tick: assert property (
      @(posedge clk) disable iff (reset)
      frame_valid |-> s_tick && (n_reg == LAST_BIT)
   );

endmodule

/* verilog/rx_break_detect.sv */
// line break detector, flags rx held low for longer than one whole frame
`timescale 1ns/1ps

module rx_break_detect
   import uart_cfg_pkg::*;
   #(
      parameter int DBIT = DEFAULT_DBIT
   )
   (
      input  logic clk,
      input  logic reset,
      input  logic rx,
      input  logic s_tick,
      output logic break_start,
      output logic line_break
   );

   // one whole frame of start, data and stop bits
   localparam break_cnt_t BREAK_TICKS = break_cnt_t'(OS_RATE * (DBIT + 2));
   localparam break_cnt_t BREAK_LAST  = BREAK_TICKS - break_cnt_t'(1);

   break_cnt_t low_cnt;

   // fires on the tick that brings the count to BREAK_TICKS
   assign break_start = s_tick && !rx && (low_cnt == BREAK_LAST);

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         low_cnt    <= '0;
         line_break <= 1'b0;
      end
      else if (s_tick)
      begin
         if (rx)
         begin
            low_cnt    <= '0;
            line_break <= 1'b0;
         end
         else
         begin
            // saturates so a long break gives one event
            if (low_cnt != BREAK_TICKS)
               low_cnt <= low_cnt + 1'b1;
            if (break_start)
               line_break <= 1'b1;
         end
      end
   end

   // one event per low run, then the level follows
   a_break_level: assert property (
      @(posedge clk) disable iff (reset)
      break_start |-> !line_break ##1 line_break
   );

endmodule

/* verilog/rx_report.sv */
// report unit, merges frame results and break events into one report stream
`timescale 1ns/1ps

module rx_report
   import uart_cfg_pkg::*;
   import uart_frame_pkg::*;
   (
      input  logic       clk,
      input  logic       reset,
      input  rx_frame_t  frame,
      input  logic       frame_valid,
      input  logic       break_start,
      input  logic       line_break,
      output rx_report_t report,
      output logic       report_valid
   );

   logic pend_reg;

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         pend_reg     <= 1'b0;
         report_valid <= 1'b0;
      end
      else
      begin
         report_valid <= frame_valid | pend_reg | break_start;
         // frame goes first, a break in the same cycle waits one cycle
         if (frame_valid)
            pend_reg <= pend_reg | break_start;
         else
            pend_reg <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (frame_valid)
      begin
         report.data          <= frame.data;
         report.framing_error <= frame.framing_error;
         report.line_break    <= line_break;
         report.overrun       <= pend_reg;
      end
      else if (pend_reg || break_start)
      begin
         report.data          <= data_t'(0);
         report.framing_error <= 1'b0;
         report.line_break    <= 1'b1;
         // a new break behind a waiting one is merged into it
         report.overrun       <= pend_reg & break_start;
      end
   end

   // back to back reports only drain a waiting break
   a_report_spacing: assert property (
      @(posedge clk) disable iff (reset)
      report_valid && !pend_reg |=> !report_valid
   );

endmodule

/* verilog/uart_rx_subsys.sv */
// uart receive subsystem, rx synchronizer, tick generator, frame and break watchers, report unit
`timescale 1ns/1ps

module uart_rx_subsys
   import uart_frame_pkg::*;
   #(
      parameter int DBIT     = 8,
      parameter int BAUD_DIV = 326
   )
   (
      input  logic       clk,
      input  logic       reset,
      input  logic       rx,
      output rx_report_t report,
      output logic       report_valid
   );

   logic      rx_meta;
   logic      rx_sync;
   logic      s_tick;
   rx_frame_t frame;
   logic      frame_valid;
   logic      break_start;
   logic      line_break;

   // idle line is high, so reset to high
   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end
      else
      begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
      end
   end

   baud_tick_gen #(.BAUD_DIV(BAUD_DIV)) u_tick (
      .clk    (clk),
      .reset  (reset),
      .s_tick (s_tick)
   );

   uart_rx #(.DBIT(DBIT)) u_rx (
      .clk         (clk),
      .reset       (reset),
      .rx          (rx_sync),
      .s_tick      (s_tick),
      .frame       (frame),
      .frame_valid (frame_valid)
   );

   rx_break_detect #(.DBIT(DBIT)) u_break (
      .clk         (clk),
      .reset       (reset),
      .rx          (rx_sync),
      .s_tick      (s_tick),
      .break_start (break_start),
      .line_break  (line_break)
   );

   rx_report u_report (
      .clk          (clk),
      .reset        (reset),
      .frame        (frame),
      .frame_valid  (frame_valid),
      .break_start  (break_start),
      .line_break   (line_break),
      .report       (report),
      .report_valid (report_valid)
   );

endmodule

/* tb/uart_rx_subsys_tb.sv */
// testbench for the uart receive subsystem, serializes frames and breaks onto rx and checks reports
`timescale 1ns/1ps

module uart_rx_subsys_tb
   import uart_cfg_pkg::*;
   import uart_frame_pkg::*;
   ();

   localparam int DBIT         = DEFAULT_DBIT;
   localparam int BAUD_DIV     = 4;
   localparam int CLK_PERIOD   = 20;
   localparam int BIT_CYCLES   = OS_RATE * BAUD_DIV;
   localparam int FRAME_CYCLES = BIT_CYCLES * (DBIT + 2);
   localparam int WAIT_LIMIT   = 2 * FRAME_CYCLES;

   // bit times per test including idle and quiet checks
   localparam int TEST_BITS    = 22 + 212 + 33 + 44 + 22 + 21;
   localparam int MARGIN_BITS  = 40;
   localparam int WATCHDOG_NS  = (TEST_BITS + MARGIN_BITS) * BIT_CYCLES * CLK_PERIOD;

   logic       clk;
   logic       reset;
   logic       rx;
   rx_report_t report;
   logic       report_valid;

   rx_report_t rep_q[$];
   integer     seed;
   int         error_count;
   int         tests_passed;
   int         tests_failed;

   uart_rx_subsys #(
      .DBIT     (DBIT),
      .BAUD_DIV (BAUD_DIV)
   ) UUT (
      .clk          (clk),
      .reset        (reset),
      .rx           (rx),
      .report       (report),
      .report_valid (report_valid)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #(CLK_PERIOD / 2) clk = ~clk;
   end

   // collect every report strobe at the falling edge
   always @(negedge clk)
   begin
      if (!reset && report_valid)
         rep_q.push_back(report);
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
      $display("Verification failed");
      $finish;
   end

   function automatic rx_report_t expect_report(input data_t d, input logic fe,
                                                input logic lb, input logic ov);
      rx_report_t r;
      r.data          = d;
      r.framing_error = fe;
      r.line_break    = lb;
      r.overrun       = ov;
      return r;
   endfunction

   task automatic drive_level(input logic level, input int cycles);
      begin
         @(posedge clk);
         rx <= level;
         repeat (cycles - 1)
            @(posedge clk);
      end
   endtask

   task automatic drive_idle(input int nbits);
      begin
         repeat (nbits)
            drive_level(1'b1, BIT_CYCLES);
      end
   endtask

   // start bit, data lsb first, one stop bit
   task automatic send_frame(input data_t d, input logic stop_level);
      begin
         drive_level(1'b0, BIT_CYCLES);
         for (int i = 0; i < DBIT; i++)
            drive_level(d[i], BIT_CYCLES);
         drive_level(stop_level, BIT_CYCLES);
      end
   endtask

   task automatic wait_report(output rx_report_t rep, output bit found, input string what);
      int count;
      begin
         count = 0;
         found = 1'b0;
         while (rep_q.size() == 0 && count < WAIT_LIMIT)
         begin
            @(negedge clk);
            count++;
         end
         if (rep_q.size() != 0)
         begin
            rep = rep_q.pop_front();
            found = 1'b1;
         end
         else
         begin
            $display("Error at %0t: no report arrived within two frame times (%s)",
                     $time, what);
            error_count++;
         end
      end
   endtask

   task automatic check_report(input rx_report_t got, input rx_report_t exp, input string what);
      begin
         if (got.data !== exp.data)
         begin
            $display("Mismatch at %0t: %s data %02h, expected %02h",
                     $time, what, got.data, exp.data);
            error_count++;
         end
         if (got.framing_error !== exp.framing_error)
         begin
            $display("Mismatch at %0t: %s framing_error %b, expected %b",
                     $time, what, got.framing_error, exp.framing_error);
            error_count++;
         end
         if (got.line_break !== exp.line_break)
         begin
            $display("Mismatch at %0t: %s line_break %b, expected %b",
                     $time, what, got.line_break, exp.line_break);
            error_count++;
         end
         if (got.overrun !== exp.overrun)
         begin
            $display("Mismatch at %0t: %s overrun %b, expected %b",
                     $time, what, got.overrun, exp.overrun);
            error_count++;
         end
      end
   endtask

   task automatic receive_and_check(input rx_report_t exp, input string what);
      rx_report_t got;
      bit         found;
      begin
         wait_report(got, found, what);
         if (found)
            check_report(got, exp, what);
      end
   endtask

   // any strobe in the window is unexpected
   task automatic check_no_report(input int cycles, input string what);
      begin
         repeat (cycles)
            @(negedge clk);
         if (rep_q.size() != 0)
         begin
            $display("Error at %0t: %0d report strobe(s) arrived when none was expected (%s)",
                     $time, rep_q.size(), what);
            error_count++;
            rep_q.delete();
         end
      end
   endtask

   task automatic finish_test(input string name, input int errors_before);
      begin
         if (error_count == errors_before)
         begin
            $display("%s: pass", name);
            tests_passed++;
         end
         else
         begin
            $display("%s: FAIL, %0d error(s)", name, error_count - errors_before);
            tests_failed++;
         end
      end
   endtask

   task automatic single_byte_test();
      int errs;
      begin
         errs = error_count;
         send_frame(8'hA5, 1'b1);
         receive_and_check(expect_report(8'hA5, 1'b0, 1'b0, 1'b0), "byte a5");
         check_no_report(FRAME_CYCLES, "after byte a5");
         drive_idle(2);
         finish_test("test 1 single byte", errs);
      end
   endtask

   task automatic random_bytes_test();
      data_t sent[$];
      data_t d;
      int    errs;
      begin
         errs = error_count;
         for (int i = 0; i < 20; i++)
         begin
            d = data_t'($random(seed));
            sent.push_back(d);
            send_frame(d, 1'b1);
         end
         for (int i = 0; i < 20; i++)
            receive_and_check(expect_report(sent[i], 1'b0, 1'b0, 1'b0),
                              $sformatf("random byte %0d", i));
         check_no_report(FRAME_CYCLES, "after random bytes");
         drive_idle(2);
         finish_test("test 2 twenty random bytes", errs);
      end
   endtask

   task automatic framing_error_test();
      int errs;
      begin
         errs = error_count;
         send_frame(8'h3C, 1'b0);
         drive_idle(1);
         send_frame(8'h5A, 1'b1);
         receive_and_check(expect_report(8'h3C, 1'b1, 1'b0, 1'b0), "low stop bit");
         receive_and_check(expect_report(8'h5A, 1'b0, 1'b0, 1'b0), "byte after rearm");
         check_no_report(FRAME_CYCLES, "after rearm byte");
         drive_idle(2);
         finish_test("test 3 framing error and rearm", errs);
      end
   endtask

   task automatic line_break_test();
      int errs;
      begin
         errs = error_count;
         drive_level(1'b0, 12 * BIT_CYCLES);
         // the all zero frame is sampled before the break count is reached
         receive_and_check(expect_report(8'h00, 1'b1, 1'b0, 1'b0), "frame inside break");
         receive_and_check(expect_report(8'h00, 1'b0, 1'b1, 1'b0), "break report");
         // long enough for a repeated frame or a second break event to show up
         check_no_report(2 * FRAME_CYCLES, "line still low");
         drive_idle(2);
         check_no_report(FRAME_CYCLES, "line released");
         finish_test("test 4 line break", errs);
      end
   endtask

   task automatic after_break_test();
      int errs;
      begin
         errs = error_count;
         drive_idle(2);
         send_frame(8'hC3, 1'b1);
         receive_and_check(expect_report(8'hC3, 1'b0, 1'b0, 1'b0), "byte after break");
         check_no_report(FRAME_CYCLES, "after break byte");
         finish_test("test 5 byte after break", errs);
      end
   endtask

   task automatic glitch_test();
      data_t all_ones;
      int    errs;
      begin
         errs = error_count;
         all_ones = data_t'((1 << DBIT) - 1);
         // low for 4 ticks and back high before the mid start sample
         drive_level(1'b0, 4 * BAUD_DIV);
         drive_level(1'b1, BIT_CYCLES);
         receive_and_check(expect_report(all_ones, 1'b0, 1'b0, 1'b0), "glitch frame");
         check_no_report(FRAME_CYCLES, "after glitch frame");
         finish_test("test 6 short glitch", errs);
      end
   endtask

   initial
   begin
      reset        = 1'b1;
      rx           = 1'b1;
      seed         = 34976;
      error_count  = 0;
      tests_passed = 0;
      tests_failed = 0;
      repeat (2)
         @(posedge clk);
      reset <= 1'b0;
      drive_idle(2);

      single_byte_test();
      random_bytes_test();
      framing_error_test();
      line_break_test();
      after_break_test();
      glitch_test();

      $display("tests passed %0d, tests failed %0d, errors %0d",
               tests_passed, tests_failed, error_count);
      if (error_count == 0 && tests_failed == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

/* uart_rx_subsys.f */
verilog/uart_cfg_pkg.sv
verilog/uart_frame_pkg.sv
verilog/baud_tick_gen.sv
verilog/uart_rx.sv
verilog/rx_break_detect.sv
verilog/rx_report.sv
verilog/uart_rx_subsys.sv
tb/uart_rx_subsys_tb.sv

/* Bender.yml */
package:
  name: uart_rx_subsys

sources:
  - files:
      - verilog/uart_cfg_pkg.sv
      - verilog/uart_frame_pkg.sv
      - verilog/baud_tick_gen.sv
      - verilog/uart_rx.sv
      - verilog/rx_break_detect.sv
      - verilog/rx_report.sv
      - verilog/uart_rx_subsys.sv
  - target: simulation
    files:
      - tb/uart_rx_subsys_tb.sv
